// File: sim.f
hw/icache_pkg.sv
hw/icache_lookup.sv
hw/icache_array.sv
hw/icache_ctrl.sv
hw/icache.sv
bench/mem_model.sv
bench/icache_tb.sv

// File: Makefile
# Verilator flow for the instruction cache testbench
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the binary exits nonzero on $fatal, so make fails with the run
sim: build
	./$(SIM_BIN) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/icache_tb.sv
// icache testbench
// directed miss, hit, eviction and abandon cases, then random fetches
module icache_tb
    import icache_pkg::*;
();

    localparam int    clock_period   = 8;
    localparam int    reset_cycles   = 10;
    localparam int    miss_limit     = 32;   // cycles, worst miss is about half
    localparam int    random_fetches = 200;
    localparam int    fetch_budget   = 300;  // every fetch of the run, rounded up
    localparam int    watchdog_time  = (reset_cycles + fetch_budget * miss_limit) * clock_period;
    localparam word_t word_mult      = 32'h9e37_79b1;
    localparam word_t word_mask      = 32'h0bad_f00d;

    logic     clock = 1'b0;
    logic     reset;
    addr_t    fetch_addr;
    logic     mispredict;
    word_t    fetch_word;
    logic     fetch_valid;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    string    test_name = "reset";
    addr_t    last_addr;            // fetch address at the previous negedge
    logic     load_rejected_last;
    int       reject_count = 0;

    icache icache_i (
        .clock       (clock),
        .reset       (reset),
        .fetch_addr  (fetch_addr),
        .fetch_word  (fetch_word),
        .fetch_valid (fetch_valid),
        .mispredict  (mispredict),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp)
    );

    mem_model mem_model_i (
        .clock   (clock),
        .reset   (reset),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #(clock_period / 2) clock = ~clock;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        stop_with_failure($sformatf("** Error [%s] %s: expected %0h, actual %0h",
                                    test_name, what, expected, actual));
    endtask

    // word at a byte address, bits 1:0 ignored
    function automatic word_t expected_word(input addr_t addr);
        addr_t word_addr;
        word_addr = {addr[xlen-1:2], 2'b00};
        return (word_addr * word_mult) ^ word_mask;
    endfunction

    function automatic addr_t block_base(input addr_t addr);
        return {addr[xlen-1:offset_bits], {offset_bits{1'b0}}};
    endfunction

    // checks that hold on every cycle, sampled away from the rising edge
    always @(negedge clock) begin
        if (reset) begin
            assert (mem_req.command == bus_none)
                else report_mismatch("command in reset", 64'(bus_none), 64'(mem_req.command));
            assert (!fetch_valid)
                else report_mismatch("fetch_valid in reset", 64'(0), 64'(fetch_valid));
            load_rejected_last = 1'b0;
        end else begin
            if (fetch_valid) begin
                assert (fetch_word == expected_word(fetch_addr))
                    else report_mismatch("fetch_word", 64'(expected_word(fetch_addr)),
                                         64'(fetch_word));
            end
            if (mem_req.command == bus_load) begin
                assert (mem_req.addr == block_base(fetch_addr))
                    else report_mismatch("load address", 64'(block_base(fetch_addr)),
                                         64'(mem_req.addr));
            end
            if (mispredict) begin
                assert (mem_req.command == bus_none)
                    else report_mismatch("command on mispredict", 64'(bus_none),
                                         64'(mem_req.command));
            end
            // a rejected load is retried while nothing abandons it
            if (load_rejected_last && !mispredict
                && fetch_addr[xlen-1:offset_bits] == last_addr[xlen-1:offset_bits]) begin
                assert (mem_req.command == bus_load)
                    else report_mismatch("retry after reject", 64'(bus_load),
                                         64'(mem_req.command));
            end
            load_rejected_last = (mem_req.command == bus_load)
                                 && !(mem_rsp.response_valid && mem_rsp.response != '0);
            if (load_rejected_last) begin
                reject_count++;
            end
        end
        last_addr = fetch_addr;
    end

    // drive an address, hold it until the word is valid
    task automatic fetch(input addr_t addr, output int cycles);
        int n;
        n = 0;
        @(posedge clock);
        fetch_addr <= addr;
        @(negedge clock);
        while (!fetch_valid) begin
            n++;
            if (n > miss_limit) begin
                stop_with_failure($sformatf("[%s] fetch of %h never became valid",
                                            test_name, addr));
            end
            @(negedge clock);
        end
        cycles = n;
    endtask

    task automatic expect_hit(input addr_t addr, input int cycles);
        assert (cycles == 0)
            else report_mismatch($sformatf("hit latency at %h", addr), 64'(0), 64'(cycles));
        assert (mem_req.command == bus_none)
            else report_mismatch("command on hit", 64'(bus_none), 64'(mem_req.command));
    endtask

    task automatic expect_miss(input addr_t addr, input int cycles);
        assert (cycles > 0)
            else stop_with_failure($sformatf("[%s] %h hit where a miss was due",
                                             test_name, addr));
    endtask

    // next accepted load, returns its transaction tag
    task automatic wait_accept(output mem_tag_t tag);
        int n;
        n = 0;
        @(negedge clock);
        while (!(mem_req.command == bus_load && mem_rsp.response_valid
                 && mem_rsp.response != '0)) begin
            n++;
            if (n > miss_limit) begin
                stop_with_failure($sformatf("[%s] no load was accepted", test_name));
            end
            @(negedge clock);
        end
        tag = mem_rsp.response;
    endtask

    task automatic wait_data_tag(input mem_tag_t tag);
        int n;
        n = 0;
        @(negedge clock);
        while (mem_rsp.data_tag != tag) begin
            n++;
            if (n > miss_limit) begin
                stop_with_failure($sformatf("[%s] data for tag %0h never came", test_name, tag));
            end
            @(negedge clock);
        end
    endtask

    // new address every cycle, nothing may be valid
    task automatic check_cold_cache();
        test_name = "cold cache";
        for (int i = 0; i < num_lines; i++) begin
            @(posedge clock);
            fetch_addr <= 32'h0000_1000 + addr_t'(i * 8);
            @(negedge clock);
            assert (!fetch_valid)
                else report_mismatch("fetch_valid", 64'(0), 64'(fetch_valid));
        end
    endtask

    task automatic check_fill_and_hit();
        addr_t base;
        int    wait_cycles;
        test_name = "fill then hit";
        base = 32'h0000_2a48;
        fetch(base + 32'd4, wait_cycles);   // upper word first
        expect_miss(base + 32'd4, wait_cycles);
        fetch(base, wait_cycles);           // lower word, same line
        expect_hit(base, wait_cycles);
        fetch(base + 32'd4, wait_cycles);
        expect_hit(base + 32'd4, wait_cycles);
        repeat (3) begin
            @(negedge clock);
            assert (mem_req.command == bus_none)
                else report_mismatch("command on held hit", 64'(bus_none),
                                     64'(mem_req.command));
        end
    endtask

    // same index 8, tags 3 and 7
    task automatic check_eviction();
        int wait_cycles;
        test_name = "eviction";
        fetch(32'h0000_0340, wait_cycles);
        expect_miss(32'h0000_0340, wait_cycles);
        fetch(32'h0000_0740, wait_cycles);
        expect_miss(32'h0000_0740, wait_cycles);
        fetch(32'h0000_0340, wait_cycles);   // evicted by the second
        expect_miss(32'h0000_0340, wait_cycles);
        fetch(32'h0000_0344, wait_cycles);
        expect_hit(32'h0000_0344, wait_cycles);
    endtask

    task automatic check_mispredict_drop();
        mem_tag_t stale;
        int       wait_cycles;
        test_name = "mispredict drop";
        @(posedge clock);
        fetch_addr <= 32'h0000_4c10;
        wait_accept(stale);
        @(posedge clock);
        mispredict <= 1'b1;      // held across the stale data
        wait_data_tag(stale);
        @(posedge clock);
        mispredict <= 1'b0;
        fetch(32'h0000_4c10, wait_cycles);
        expect_miss(32'h0000_4c10, wait_cycles);
    endtask

    task automatic check_address_change_drop();
        mem_tag_t stale;
        int       wait_cycles;
        test_name = "address change drop";
        @(posedge clock);
        fetch_addr <= 32'h0000_5518;
        wait_accept(stale);
        @(posedge clock);
        fetch_addr <= 32'h0000_6620;   // other index, miss moves on
        wait_data_tag(stale);
        fetch(32'h0000_5518, wait_cycles);
        expect_miss(32'h0000_5518, wait_cycles);
    endtask

    // 1 KiB window, four tags per index, lots of conflicts
    task automatic check_random_fetches();
        addr_t addr;
        int    wait_cycles;
        test_name = "random fetches";
        for (int i = 0; i < random_fetches; i++) begin
            addr = addr_t'(($urandom % 256) * 4);
            fetch(addr, wait_cycles);
        end
    endtask

    initial begin
        #(watchdog_time);
        stop_with_failure("watchdog expired, the run did not finish in time");
    end

    initial begin
        void'($urandom(32'h08ac89a1));
        reset      = 1'b1;
        fetch_addr = '0;
        mispredict = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;

        check_cold_cache();
        check_fill_and_hit();
        check_eviction();
        check_mispredict_drop();
        check_address_change_drop();
        check_random_fetches();

        @(posedge clock);
        if (reject_count == 0) begin
            stop_with_failure("memory never rejected a load, retry path not reached");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// File: bench/mem_model.sv
// tagged memory for the icache bench
// random reject, rotating nonzero tags, data 2 to 9 cycles after accept
module mem_model
    import icache_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    localparam int    min_latency  = 2;
    localparam int    latency_span = 8;   // 2..9
    localparam int    max_rejects  = 3;   // forced accept after this many in a row
    localparam word_t data_mult    = 32'h9e37_79b1;
    localparam word_t data_mask    = 32'h0bad_f00d;

    mem_tag_t next_tag;      // 1..15, never zero
    logic     accept_roll;   // answer for the current cycle
    int       reject_run;
    int       cycle_count;
    mem_tag_t data_tag_q;
    block_t   data_q;

    // accepted loads waiting for their slot
    mem_tag_t pend_tag[$];
    block_t   pend_block[$];
    int       pend_due[$];

    // each word is a hash of its own byte address
    function automatic block_t block_for(input addr_t addr);
        addr_t base;
        word_t low;
        word_t high;
        base = {addr[xlen-1:offset_bits], {offset_bits{1'b0}}};
        low  = (base * data_mult) ^ data_mask;
        high = ((base + 32'd4) * data_mult) ^ data_mask;
        return {high, low};
    endfunction

    // accept or reject in the same cycle as the load
    always_comb begin
        mem_rsp.response_valid = mem_req.command == bus_load;
        mem_rsp.response       = (mem_req.command == bus_load && accept_roll) ? next_tag : '0;
        mem_rsp.data_tag       = data_tag_q;   // zero when idle
        mem_rsp.data           = data_q;
    end

    always @(posedge clock) begin : model_step
        int run_next;
        int slot;
        if (reset) begin
            pend_tag.delete();
            pend_block.delete();
            pend_due.delete();
            next_tag    <= 4'h1;
            accept_roll <= 1'b0;
            reject_run  <= 0;
            cycle_count <= 0;
            data_tag_q  <= '0;
            data_q      <= '0;
        end else begin
            run_next = reject_run;
            if (mem_req.command == bus_load) begin
                if (mem_rsp.response != '0) begin
                    pend_tag.push_back(mem_rsp.response);
                    pend_block.push_back(block_for(mem_req.addr));
                    pend_due.push_back(cycle_count + min_latency
                                       + int'($urandom % latency_span));
                    next_tag <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
                    run_next = 0;
                end else begin
                    run_next = reject_run + 1;
                end
            end
            reject_run  <= run_next;
            accept_roll <= (run_next >= max_rejects) || (($urandom % 3) != 0);

            // oldest due entry goes out, one block per cycle
            slot = -1;
            for (int i = 0; i < pend_due.size(); i++) begin
                if (slot < 0 && pend_due[i] <= cycle_count) begin
                    slot = i;
                end
            end
            if (slot >= 0) begin
                data_tag_q <= pend_tag[slot];
                data_q     <= pend_block[slot];
                pend_tag.delete(slot);
                pend_block.delete(slot);
                pend_due.delete(slot);
            end else begin
                data_tag_q <= '0;
            end
            cycle_count <= cycle_count + 1;
        end
    end

endmodule

// File: hw/icache.sv
// instruction cache top
// 32 lines x 8 bytes, direct mapped, one word per lookup
// hit path is combinational, misses go out on the tagged memory bus
module icache
    import icache_pkg::*;
(
    input  logic     clock,
    input  logic     reset,

    // fetch side
    input  addr_t    fetch_addr,
    output word_t    fetch_word,
    output logic     fetch_valid,   // word is good this cycle

    // commit side
    input  logic     mispredict,

    // memory side
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    line_index_t  line_index;   // lookup -> array
    icache_line_t read_line;    // array -> lookup
    fill_t        fill;         // ctrl -> array

    icache_ctrl ctrl_i (
        .clock      (clock),
        .reset      (reset),
        .mispredict (mispredict),
        .fetch_addr (fetch_addr),
        .hit        (fetch_valid),   // hit is the fetch valid
        .mem_rsp    (mem_rsp),
        .mem_req    (mem_req),
        .fill       (fill)
    );

    icache_array array_i (
        .clock     (clock),
        .reset     (reset),
        .index     (line_index),
        .read_line (read_line),
        .fill      (fill)
    );

    // tag compare stays inside lookup
    icache_lookup lookup_i (
        .fetch_addr (fetch_addr),
        .read_line  (read_line),
        .index      (line_index),
        .tag        (),
        .word       (fetch_word),
        .hit        (fetch_valid)
    );

endmodule

// File: hw/icache_ctrl.sv
// miss handling
// idle -> request (until accepted) -> wait for tagged data -> fill
module icache_ctrl
    import icache_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     mispredict,   // from commit, kills the miss in flight
    input  addr_t    fetch_addr,
    input  logic     hit,          // from lookup
    input  mem_rsp_t mem_rsp,
    output mem_req_t mem_req,
    output fill_t    fill
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    block_addr_t prev_block;    // block address seen last cycle
    addr_t       miss_addr;     // aligned address of the outstanding miss
    mem_tag_t    cur_mem_tag;   // accepted transaction, zero when none

    logic addr_changed;
    logic abandon;
    logic accepted;
    logic data_match;

    // any change of block address counts, even inside the same line
    assign addr_changed = fetch_addr[xlen-1:offset_bits] != prev_block;

    // fetch moved on or commit flushed, drop whatever is in flight
    assign abandon = addr_changed || mispredict;

    // nonzero response in the same cycle as the load
    assign accepted = (state == st_request) && !abandon
                      && mem_rsp.response_valid && (mem_rsp.response != '0);

    // returning block belongs to our transaction
    assign data_match = (state == st_wait_data) && !abandon
                        && (mem_rsp.data_tag == cur_mem_tag);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                // one idle cycle registers the new address first
                if (!hit && !mispredict) begin
                    next_state = st_request;
                end
            end
            st_request: begin
                if (abandon) begin
                    next_state = st_idle;
                end else if (accepted) begin
                    next_state = st_wait_data;
                end
                // rejected, stay and retry next cycle
            end
            st_wait_data: begin
                if (abandon || data_match) begin
                    next_state = st_idle;   // line hits from the next cycle on
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= st_idle;
            prev_block  <= '0;
            cur_mem_tag <= '0;
        end else begin
            state      <= next_state;
            prev_block <= fetch_addr[xlen-1:offset_bits];

            // a late fill with a dropped tag matches nothing
            if (abandon || data_match) begin
                cur_mem_tag <= '0;
            end else if (accepted) begin
                cur_mem_tag <= mem_rsp.response;
            end
        end
    end

    // miss address, tracked while idle, frozen for the rest of the miss
    always_ff @(posedge clock) begin
        if (state == st_idle) begin
            miss_addr <= {fetch_addr[xlen-1:offset_bits], {offset_bits{1'b0}}};
        end
    end

    // load held every cycle until accepted, withdrawn on abandon
    always_comb begin
        if ((state == st_request) && !abandon) begin
            mem_req.command = bus_load;
        end else begin
            mem_req.command = bus_none;
        end
        mem_req.addr = miss_addr;
    end

    // fill uses the recorded miss, not the live fetch address
    always_comb begin
        fill.enable = data_match;
        fill.index  = miss_addr[index_lsb +: index_bits];
        fill.tag    = miss_addr[tag_lsb +: tag_bits];
        fill.data   = mem_rsp.data;
    end

endmodule

// File: hw/icache_array.sv
// line storage: valid bits in flops with reset,
// tag and data in plain arrays that only the fill writes
module icache_array
    import icache_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  line_index_t  index,       // read address from lookup
    output icache_line_t read_line,
    input  fill_t        fill         // write port from the controller
);

    logic [num_lines-1:0] valid_bits;
    line_tag_t            tag_mem  [num_lines];
    block_t               data_mem [num_lines];

    // valid bits, cleared on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;   // whole cache invalid
        end else if (fill.enable) begin
            valid_bits[fill.index] <= 1'b1;
        end
    end

    // tag and block payload
    always_ff @(posedge clock) begin
        if (fill.enable) begin
            tag_mem[fill.index]  <= fill.tag;
            data_mem[fill.index] <= fill.data;
        end
    end

    // async read, a fill shows up the cycle after its edge
    always_comb begin
        read_line.valid = valid_bits[index];
        read_line.tag   = tag_mem[index];
        read_line.data  = data_mem[index];
    end

endmodule

// File: hw/icache_lookup.sv
// combinational tag check and word select for the current fetch
module icache_lookup
    import icache_pkg::*;
(
    input  addr_t        fetch_addr,
    input  icache_line_t read_line,   // line at index, from the array
    output line_index_t  index,
    output line_tag_t    tag,
    output word_t        word,
    output logic         hit
);

    logic word_sel;   // high word of the block
    logic tag_match;

    // address fields
    // bits above the tag field are not compared, so addresses alias every 64 KiB
    assign index    = fetch_addr[index_lsb +: index_bits];
    assign tag      = fetch_addr[tag_lsb +: tag_bits];
    assign word_sel = fetch_addr[word_sel_bit];

    assign tag_match = read_line.tag == tag;

    // the only hit condition in the design
    assign hit = read_line.valid && tag_match;

    // little endian block, word 0 in the low half
    always_comb begin
        if (word_sel) begin
            word = read_line.data[xlen +: xlen];
        end else begin
            word = read_line.data[0 +: xlen];
        end
    end

endmodule

// File: hw/icache_pkg.sv
package icache_pkg;

    // address and word width
    localparam int xlen = 32;

    // cache geometry, direct mapped, 32 x 8 bytes
    localparam int num_lines   = 32;
    localparam int index_bits  = 5;
    localparam int tag_bits    = 8;
    localparam int offset_bits = 3;

    localparam int mem_tag_bits = 4;          // memory transaction tag
    localparam int block_bits   = 2 * xlen;   // two words per block

    // address field positions
    localparam int word_sel_bit = 2;                       // picks upper or lower word
    localparam int index_lsb    = offset_bits;
    localparam int tag_lsb      = offset_bits + index_bits; // tag only covers bits 15:8

    typedef logic [xlen-1:0]             addr_t;
    typedef logic [xlen-1:0]             word_t;
    typedef logic [block_bits-1:0]       block_t;
    typedef logic [xlen-offset_bits-1:0] block_addr_t;  // address without byte offset
    typedef logic [index_bits-1:0]       line_index_t;
    typedef logic [tag_bits-1:0]         line_tag_t;
    typedef logic [mem_tag_bits-1:0]     mem_tag_t;     // zero means no transaction

    // store encoding exists on the bus, never issued here
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_command_t;

    typedef struct packed {
        logic      valid;
        line_tag_t tag;
        block_t    data;
    } icache_line_t;

    // cache to memory
    typedef struct packed {
        bus_command_t command;
        addr_t        addr;
    } mem_req_t;

    // memory to cache
    typedef struct packed {
        mem_tag_t response;        // accept tag, same cycle as request
        logic     response_valid;
        mem_tag_t data_tag;        // tag of the block on data
        block_t   data;
    } mem_rsp_t;

    // controller to line array
    typedef struct packed {
        logic        enable;
        line_index_t index;
        line_tag_t   tag;
        block_t      data;
    } fill_t;

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_wait_data
    } ctrl_state_t;

endpackage
